//--- logic/accumulatorUnit.sv
`timescale 1ns/10ps
`default_nettype none

`include "veripac_params.svh"

module accumulatorUnit (
    input wire logic clk,
    input wire logic reset,
    input wire veriPacIsaPkg::aluOp_e aluOp,
    input wire logic [`VP_DATA_W-1:0] regData,
    input wire logic [`VP_DATA_W-1:0] operand,
    output logic [`VP_DATA_W-1:0] accumulator,
    output logic carry,
    output logic branchTaken
);

    always_ff @(posedge clk) begin
        if (reset) begin
            accumulator <= '0;
            carry <= 1'b0;
        end else begin
            case (aluOp)
                veriPacIsaPkg::ALU_CLR: accumulator <= '0;
                veriPacIsaPkg::ALU_INC: {carry, accumulator} <= {1'b0, accumulator} + 1'b1;
                veriPacIsaPkg::ALU_DEC: {carry, accumulator} <= {1'b0, accumulator} - 1'b1;
                veriPacIsaPkg::ALU_LOADIMM: accumulator <= operand;
                veriPacIsaPkg::ALU_LOADREG: accumulator <= regData;
                veriPacIsaPkg::ALU_ADD: begin
                    {carry, accumulator} <= {1'b0, regData} + {1'b0, accumulator};
                end
                // Register minus accumulator, carry holds the borrow
                veriPacIsaPkg::ALU_SUB: begin
                    {carry, accumulator} <= {1'b0, regData} - {1'b0, accumulator};
                end
                default: begin
                end
            endcase
        end
    end

    always_comb begin
        case (aluOp)
            veriPacIsaPkg::ALU_TESTNE: branchTaken = regData != accumulator;
            veriPacIsaPkg::ALU_TESTEQ: branchTaken = regData == accumulator;
            veriPacIsaPkg::ALU_TESTGT: branchTaken = regData > accumulator;
            veriPacIsaPkg::ALU_TESTLT: branchTaken = regData < accumulator;
            veriPacIsaPkg::ALU_TESTNZ: branchTaken = accumulator != '0;
            veriPacIsaPkg::ALU_TESTZ: branchTaken = accumulator == '0;
            veriPacIsaPkg::ALU_TESTC: branchTaken = carry;
            veriPacIsaPkg::ALU_TESTNC: branchTaken = !carry;
            default: branchTaken = 1'b0;
        endcase
    end

    branchOnlyOnTest: assert property (@(posedge clk) disable iff (reset)
        aluOp < veriPacIsaPkg::ALU_TESTNE |-> !branchTaken);

endmodule

`default_nettype wire

//--- logic/controlUnit.sv
`timescale 1ns/10ps
`default_nettype none

`include "veripac_params.svh"

module controlUnit (
    input wire logic clk,
    input wire logic reset,
    input wire logic step,
    input wire logic rd,
    input wire logic wr,
    input wire logic [`VP_DATA_W-1:0] fetchData,
    input wire logic [`VP_DATA_W-1:0] accum,
    input wire logic branchTaken,
    output logic [`VP_DATA_W-1:0] fetchAddr,
    output veriPacIsaPkg::ucState_e state,
    output logic [`VP_DATA_W-1:0] instruction,
    output logic [`VP_DATA_W-1:0] operand,
    output veriPacIsaPkg::aluOp_e aluOp,
    output logic regWrite,
    output logic [`VP_DATA_W-1:0] regWriteData
);

    logic stepPrev;
    logic stepEvent;
    logic execStep;
    logic atEnd;
    logic isTwoByte;
    logic isJump;
    logic execRegWrite;
    veriPacIsaPkg::aluOp_e execOp;

    // Host activity freezes stepping
    assign stepEvent = step && !stepPrev && !rd && !wr;
    assign execStep = stepEvent && state == veriPacIsaPkg::UC_EXEC;
    assign atEnd = fetchAddr >= `VP_DATA_W'(`VP_RAM_LEN);

    assign isTwoByte = (instruction[7:4] >= 4'h1 && instruction[7:4] <= 4'h6)
        || instruction == veriPacIsaPkg::OP_LDVANN;

    always_comb begin
        execOp = veriPacIsaPkg::ALU_NONE;
        execRegWrite = 1'b0;
        isJump = 1'b0;
        case (instruction[7:4])
            veriPacIsaPkg::GRP_BNER: execOp = veriPacIsaPkg::ALU_TESTNE;
            veriPacIsaPkg::GRP_BEQR: execOp = veriPacIsaPkg::ALU_TESTEQ;
            veriPacIsaPkg::GRP_BGTR: execOp = veriPacIsaPkg::ALU_TESTGT;
            veriPacIsaPkg::GRP_BLTR: execOp = veriPacIsaPkg::ALU_TESTLT;
            veriPacIsaPkg::GRP_LDVR: execRegWrite = 1'b1;
            veriPacIsaPkg::GRP_STOR: execRegWrite = 1'b1;
            veriPacIsaPkg::GRP_LDAR: execOp = veriPacIsaPkg::ALU_LOADREG;
            veriPacIsaPkg::GRP_SUBR: execOp = veriPacIsaPkg::ALU_SUB;
            veriPacIsaPkg::GRP_ADDR: execOp = veriPacIsaPkg::ALU_ADD;
            default: begin
                // Whole-byte opcodes, anything unknown runs as NOP
                case (instruction)
                    veriPacIsaPkg::OP_CLR: execOp = veriPacIsaPkg::ALU_CLR;
                    veriPacIsaPkg::OP_INC: execOp = veriPacIsaPkg::ALU_INC;
                    veriPacIsaPkg::OP_DEC: execOp = veriPacIsaPkg::ALU_DEC;
                    veriPacIsaPkg::OP_LDVANN: execOp = veriPacIsaPkg::ALU_LOADIMM;
                    veriPacIsaPkg::OP_BDCNN: execOp = veriPacIsaPkg::ALU_TESTNZ;
                    veriPacIsaPkg::OP_BRZNN: execOp = veriPacIsaPkg::ALU_TESTZ;
                    veriPacIsaPkg::OP_BCNN: execOp = veriPacIsaPkg::ALU_TESTC;
                    veriPacIsaPkg::OP_BNCNN: execOp = veriPacIsaPkg::ALU_TESTNC;
                    veriPacIsaPkg::OP_GTONN: isJump = 1'b1;
                    default: begin
                    end
                endcase
            end
        endcase
    end

    assign aluOp = execStep ? execOp : veriPacIsaPkg::ALU_NONE;
    assign regWrite = execStep && execRegWrite;
    assign regWriteData = (instruction[7:4] == veriPacIsaPkg::GRP_STOR) ? accum : operand;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= veriPacIsaPkg::UC_FETCH1;
            fetchAddr <= '0;
            instruction <= '0;
            operand <= '0;
            // A step already held high needs a fresh edge
            stepPrev <= 1'b1;
        end else if (!rd && !wr) begin
            stepPrev <= step;
            if (stepEvent) begin
                case (state)
                    veriPacIsaPkg::UC_FETCH1: begin
                        if (atEnd) begin
                            state <= veriPacIsaPkg::UC_HALT;
                        end else begin
                            instruction <= fetchData;
                            fetchAddr <= fetchAddr + 1'b1;
                            state <= veriPacIsaPkg::UC_FETCH2;
                        end
                    end
                    veriPacIsaPkg::UC_FETCH2: begin
                        if (!isTwoByte) begin
                            operand <= '0;
                            state <= veriPacIsaPkg::UC_EXEC;
                        end else if (atEnd) begin
                            state <= veriPacIsaPkg::UC_HALT;
                        end else begin
                            operand <= fetchData;
                            fetchAddr <= fetchAddr + 1'b1;
                            state <= veriPacIsaPkg::UC_EXEC;
                        end
                    end
                    veriPacIsaPkg::UC_EXEC: begin
                        if (isJump || branchTaken) begin
                            fetchAddr <= operand;
                        end
                        if (instruction == veriPacIsaPkg::OP_HALT) begin
                            state <= veriPacIsaPkg::UC_HALT;
                        end else begin
                            state <= veriPacIsaPkg::UC_FETCH1;
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    frozenDuringHost: assert property (@(posedge clk) disable iff (reset)
        (rd || wr) |=> $stable(instruction) && $stable(fetchAddr));

    haltIsAbsorbing: assert property (@(posedge clk) disable iff (reset)
        state == veriPacIsaPkg::UC_HALT |=> state == veriPacIsaPkg::UC_HALT);

endmodule

`default_nettype wire

//--- logic/hostPort.sv
`timescale 1ns/10ps
`default_nettype none

`include "veripac_params.svh"

module hostPort (
    input wire logic [`VP_DATA_W-1:0] addr,
    input wire logic rd,
    input wire logic wr,
    input wire logic [`VP_DATA_W-1:0] ramRdData,
    input wire logic [`VP_DATA_W-1:0] regRdData,
    input wire veriPacIsaPkg::ucState_e state,
    input wire logic carry,
    input wire logic [`VP_DATA_W-1:0] accumulator,
    input wire logic [`VP_DATA_W-1:0] pc,
    input wire logic [`VP_DATA_W-1:0] instruction,
    input wire logic [`VP_DATA_W-1:0] operand,
    output logic [`VP_DATA_W-1:0] dout,
    output logic ramWrite,
    output logic regWrite
);

    veriPacMapPkg::region_e region;
    logic [`VP_DATA_W-1:0] ctrlByte;
    logic [`VP_DATA_W-1:0] specialData;

    always_comb begin
        if (addr < `VP_DATA_W'(`VP_RAM_LEN)) begin
            region = veriPacMapPkg::RGN_RAM;
        end else if (addr >= `VP_ADDR_REGS) begin
            region = veriPacMapPkg::RGN_REGS;
        end else if (addr == `VP_ADDR_CONTROL || (addr >= `VP_ADDR_ACC && addr <= `VP_ADDR_DC)) begin
            region = veriPacMapPkg::RGN_SPECIAL;
        end else begin
            region = veriPacMapPkg::RGN_NONE;
        end
    end

    // Special registers are read only
    assign ramWrite = wr && region == veriPacMapPkg::RGN_RAM;
    assign regWrite = wr && region == veriPacMapPkg::RGN_REGS;

    always_comb begin
        ctrlByte = '0;
        ctrlByte[veriPacMapPkg::CTRL_STATE_LSB +: 2] = state;
        ctrlByte[veriPacMapPkg::CTRL_CARRY_BIT] = carry;
    end

    always_comb begin
        case (addr)
            `VP_ADDR_CONTROL: specialData = ctrlByte;
            `VP_ADDR_ACC: specialData = accumulator;
            `VP_ADDR_PC: specialData = pc;
            `VP_ADDR_IR: specialData = instruction;
            `VP_ADDR_DC: specialData = operand;
            default: specialData = '0;
        endcase
    end

    always_comb begin
        if (!rd) begin
            dout = '0;
        end else begin
            case (region)
                veriPacMapPkg::RGN_RAM: dout = ramRdData;
                veriPacMapPkg::RGN_REGS: dout = regRdData;
                veriPacMapPkg::RGN_SPECIAL: dout = specialData;
                default: dout = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/programRam.sv
`timescale 1ns/10ps
`default_nettype none

`include "veripac_params.svh"

module programRam (
    input wire logic clk,
    input wire logic hostWrite,
    input wire logic [`VP_DATA_W-1:0] hostAddr,
    input wire logic [`VP_DATA_W-1:0] hostData,
    input wire logic [`VP_DATA_W-1:0] fetchAddr,
    output logic [`VP_DATA_W-1:0] hostRdData,
    output logic [`VP_DATA_W-1:0] fetchData
);

    logic [`VP_DATA_W-1:0] mem [`VP_RAM_LEN] = '{default: '0};

    always_ff @(posedge clk) begin
        if (hostWrite) begin
            mem[hostAddr] <= hostData;
        end
    end

    // Out of range reads return zero
    assign hostRdData = (hostAddr < `VP_DATA_W'(`VP_RAM_LEN)) ? mem[hostAddr] : '0;
    assign fetchData = (fetchAddr < `VP_DATA_W'(`VP_RAM_LEN)) ? mem[fetchAddr] : '0;

    hostWriteInRange: assert property (@(posedge clk)
        hostWrite |-> hostAddr < `VP_DATA_W'(`VP_RAM_LEN));

endmodule

`default_nettype wire

//--- logic/registerFile.sv
`timescale 1ns/10ps
`default_nettype none

`include "veripac_params.svh"

module registerFile (
    input wire logic clk,
    input wire logic hostWrite,
    input wire logic [`VP_REG_IDX_W-1:0] hostIdx,
    input wire logic [`VP_DATA_W-1:0] hostData,
    input wire logic execWrite,
    input wire logic [`VP_REG_IDX_W-1:0] execIdx,
    input wire logic [`VP_DATA_W-1:0] execData,
    input wire logic [`VP_REG_IDX_W-1:0] readIdx,
    output logic [`VP_DATA_W-1:0] hostRdData,
    output logic [`VP_DATA_W-1:0] regData
);

    logic [`VP_DATA_W-1:0] regs [`VP_NUM_REGS] = '{default: '0};

    always_ff @(posedge clk) begin
        if (hostWrite) begin
            regs[hostIdx] <= hostData;
        end else if (execWrite) begin
            regs[execIdx] <= execData;
        end
    end

    assign hostRdData = regs[hostIdx];
    assign regData = regs[readIdx];

    // Host access freezes execution, so the two writers never meet
    noWriteCollision: assert property (@(posedge clk) !(hostWrite && execWrite));

endmodule

`default_nettype wire

//--- logic/veriPacIsaPkg.sv
`default_nettype none

`include "veripac_params.svh"

package veriPacIsaPkg;

    typedef enum logic [1:0] {
        UC_FETCH1 = 2'd0,
        UC_FETCH2 = 2'd1,
        UC_EXEC = 2'd2,
        UC_HALT = 2'd3
    } ucState_e;

    // Whole-byte opcodes
    typedef enum logic [`VP_DATA_W-1:0] {
        OP_NOP = 8'h00,
        OP_CLR = 8'h01,
        OP_DEC = 8'h02,
        OP_INC = 8'h03,
        OP_LDVANN = 8'h0A,
        OP_BDCNN = 8'h11,
        OP_GTONN = 8'h12,
        OP_BRZNN = 8'h13,
        OP_BNCNN = 8'h15,
        OP_BCNN = 8'h16,
        OP_HALT = 8'hFF
    } opcode_e;

    // Upper nibble, register index in the lower one
    typedef enum logic [3:0] {
        GRP_BNER = 4'h2,
        GRP_BEQR = 4'h3,
        GRP_BGTR = 4'h4,
        GRP_BLTR = 4'h5,
        GRP_LDVR = 4'h6,
        GRP_LDAR = 4'h9,
        GRP_STOR = 4'hA,
        GRP_SUBR = 4'hD,
        GRP_ADDR = 4'hE
    } regGroup_e;

    // Tests are kept last so a range check finds them
    typedef enum logic [3:0] {
        ALU_NONE, ALU_CLR, ALU_INC, ALU_DEC,
        ALU_LOADIMM, ALU_LOADREG, ALU_ADD, ALU_SUB,
        ALU_TESTNE, ALU_TESTEQ, ALU_TESTGT, ALU_TESTLT,
        ALU_TESTNZ, ALU_TESTZ, ALU_TESTC, ALU_TESTNC
    } aluOp_e;

endpackage

`default_nettype wire

//--- logic/veriPacMapPkg.sv
`default_nettype none

package veriPacMapPkg;

    // Host address regions
    typedef enum logic [1:0] {
        RGN_RAM = 2'd0,
        RGN_SPECIAL = 2'd1,
        RGN_REGS = 2'd2,
        RGN_NONE = 2'd3
    } region_e;

    // Control register layout
    localparam int unsigned CTRL_STATE_LSB = 0;
    localparam int unsigned CTRL_CARRY_BIT = 2;

endpackage

`default_nettype wire

//--- logic/veriPacTop.sv
`timescale 1ns/10ps
`default_nettype none

`include "veripac_params.svh"

module veriPacTop (
    input wire logic clk,
    input wire logic reset,
    input wire logic [`VP_DATA_W-1:0] addr,
    input wire logic rd,
    input wire logic wr,
    input wire logic [`VP_DATA_W-1:0] din,
    input wire logic step,
    output logic [`VP_DATA_W-1:0] dout
);

    logic ramWrite;
    logic regHostWrite;
    logic [`VP_DATA_W-1:0] ramRdData;
    logic [`VP_DATA_W-1:0] regRdData;
    logic [`VP_DATA_W-1:0] fetchAddr;
    logic [`VP_DATA_W-1:0] fetchData;
    logic [`VP_DATA_W-1:0] instruction;
    logic [`VP_DATA_W-1:0] operand;
    logic [`VP_DATA_W-1:0] regData;
    logic [`VP_DATA_W-1:0] regWriteData;
    logic [`VP_DATA_W-1:0] accumulator;
    logic regWrite;
    logic carry;
    logic branchTaken;
    veriPacIsaPkg::ucState_e state;
    veriPacIsaPkg::aluOp_e aluOp;

    programRam i_programRam (
        .clk(clk), .hostWrite(ramWrite), .hostAddr(addr), .hostData(din),
        .fetchAddr(fetchAddr), .hostRdData(ramRdData), .fetchData(fetchData)
    );

    // Register index sits in the low nibble of both the host address and the IR
    registerFile i_registerFile (
        .clk(clk), .hostWrite(regHostWrite), .hostIdx(addr[`VP_REG_IDX_W-1:0]),
        .hostData(din), .execWrite(regWrite), .execIdx(instruction[`VP_REG_IDX_W-1:0]),
        .execData(regWriteData), .readIdx(instruction[`VP_REG_IDX_W-1:0]),
        .hostRdData(regRdData), .regData(regData)
    );

    accumulatorUnit i_accumulatorUnit (
        .clk(clk), .reset(reset), .aluOp(aluOp), .regData(regData), .operand(operand),
        .accumulator(accumulator), .carry(carry), .branchTaken(branchTaken)
    );

    controlUnit i_controlUnit (
        .clk(clk), .reset(reset), .step(step), .rd(rd), .wr(wr), .fetchData(fetchData),
        .accum(accumulator), .branchTaken(branchTaken), .fetchAddr(fetchAddr),
        .state(state), .instruction(instruction), .operand(operand), .aluOp(aluOp),
        .regWrite(regWrite), .regWriteData(regWriteData)
    );

    hostPort i_hostPort (
        .addr(addr), .rd(rd), .wr(wr), .ramRdData(ramRdData), .regRdData(regRdData),
        .state(state), .carry(carry), .accumulator(accumulator), .pc(fetchAddr),
        .instruction(instruction), .operand(operand), .dout(dout),
        .ramWrite(ramWrite), .regWrite(regHostWrite)
    );

endmodule

`default_nettype wire

//--- logic/veripac_params.svh
`ifndef VERIPAC_PARAMS_SVH
`define VERIPAC_PARAMS_SVH

// Data path and host address width
`define VP_DATA_W 8

`define VP_RAM_LEN 202
`define VP_NUM_REGS 16
`define VP_REG_IDX_W 4

// Host memory map, keyboard slot at 203 left empty
`define VP_ADDR_CONTROL 8'd202
`define VP_ADDR_ACC 8'd204
`define VP_ADDR_PC 8'd205
`define VP_ADDR_IR 8'd206
`define VP_ADDR_DC 8'd207
`define VP_ADDR_REGS 8'd240

`endif

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator, verdict taken from the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module veriPacTb \
    -f sources.f -Mdir obj_dir -o veriPacSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/veriPacSim > "$LOG" 2>&1
runStatus=$?
cat "$LOG"

if grep -q "=== FAIL ===" "$LOG"; then
    exit 1
fi
if [ $runStatus -ne 0 ]; then
    echo "Simulation exited with status $runStatus"
    exit 1
fi
exit 0

//--- sim/veriPacTb.sv
`timescale 1ns/10ps
`default_nettype none

`include "veripac_params.svh"

module veriPacTb;

    localparam int NUM_ROWS = 15;
    localparam int MAX_STEPS = 64;
    localparam int RESET_CYCLES = 16;
    localparam int WRITE_CYCLES = 2;
    localparam int READ_CYCLES = 2;
    // One step pulse plus the control register poll that follows it
    localparam int STEP_CYCLES = 3 + READ_CYCLES;
    localparam int LOAD_CYCLES = RESET_CYCLES + 2 + 10 * WRITE_CYCLES;
    localparam int READBACK_CYCLES = 6 * READ_CYCLES + STEP_CYCLES;
    localparam int ROW_CYCLES = LOAD_CYCLES + MAX_STEPS * STEP_CYCLES + READBACK_CYCLES;
    // Two spare rows for the freeze and long pulse tests
    localparam int TIMEOUT_CYCLES = (NUM_ROWS + 2) * ROW_CYCLES;

    localparam logic [1:0] ST_HALT = 2'(veriPacIsaPkg::UC_HALT);
    localparam logic [1:0] ST_FETCH2 = 2'(veriPacIsaPkg::UC_FETCH2);

    logic clk = 1'b0;
    logic reset = 1'b1;
    logic [7:0] addr = '0;
    logic rd = 1'b0;
    logic wr = 1'b0;
    logic [7:0] din = '0;
    logic step = 1'b0;
    logic [7:0] dout;

    int cycleCount = 0;

    // Program bytes packed with the first byte in the top bits
    string rowName [NUM_ROWS];
    logic [63:0] rowProgram [NUM_ROWS];
    logic [7:0] rowR3 [NUM_ROWS];
    logic [7:0] rowAcc [NUM_ROWS];
    logic [7:0] rowR5 [NUM_ROWS];
    logic rowCarry [NUM_ROWS];
    logic [7:0] rowPc [NUM_ROWS];
    logic [1:0] rowState [NUM_ROWS];

    veriPacTop i_veriPacTop (
        .clk(clk), .reset(reset), .addr(addr), .rd(rd), .wr(wr),
        .din(din), .step(step), .dout(dout)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("=== FAIL ===");
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $fatal(1);
        end
    end

    task automatic addRow(input int idx, input string name, input logic [63:0] prog,
                          input logic [7:0] r3, input logic [7:0] acc, input logic [7:0] r5,
                          input logic carry, input logic [7:0] pc);
        rowName[idx] = name;
        rowProgram[idx] = prog;
        rowR3[idx] = r3;
        rowAcc[idx] = acc;
        rowR5[idx] = r5;
        rowCarry[idx] = carry;
        rowPc[idx] = pc;
        rowState[idx] = ST_HALT;
    endtask

    task automatic checkValue(input string testName, input string what,
                              input int expected, input int actual);
        assert (actual == expected) else begin
            $display("CHECK FAILED %s %s: expected %0d, actual %0d",
                     testName, what, expected, actual);
            $display("=== FAIL ===");
            $fatal(1);
        end
    endtask

    task automatic applyReset();
        @(posedge clk);
        reset <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    endtask

    task automatic writeByte(input logic [7:0] a, input logic [7:0] d);
        @(posedge clk);
        addr <= a;
        din <= d;
        wr <= 1'b1;
        @(posedge clk);
        wr <= 1'b0;
    endtask

    // Read data is combinational and sampled mid cycle
    task automatic readByte(input logic [7:0] a, output logic [7:0] d);
        @(posedge clk);
        addr <= a;
        rd <= 1'b1;
        @(negedge clk);
        d = dout;
        @(posedge clk);
        rd <= 1'b0;
    endtask

    task automatic pulseStep();
        @(posedge clk);
        step <= 1'b1;
        @(posedge clk);
        step <= 1'b0;
        @(posedge clk);
    endtask

    task automatic runUntilHalt();
        logic [7:0] ctrl;
        int count;
        count = 0;
        ctrl = '0;
        while (count < MAX_STEPS
               && ctrl[veriPacMapPkg::CTRL_STATE_LSB +: 2] != ST_HALT) begin
            pulseStep();
            readByte(`VP_ADDR_CONTROL, ctrl);
            count++;
        end
    endtask

    initial begin
        logic [7:0] value;

        // name, program, R3, acc, R5, carry, final PC
        addRow(0, "add_carry", 64'h0AC8_6364_E3A5_FF00, 8'd0, 8'd44, 8'd44, 1'b1, 8'd7);
        addRow(1, "sub_borrow", 64'h0A32_D3A5_FF00_0000, 8'd30, 8'd236, 8'd236, 1'b1, 8'd5);
        addRow(2, "sub_no_borrow", 64'h0A32_D3A5_FF00_0000, 8'd80, 8'd30, 8'd30, 1'b0, 8'd5);
        addRow(3, "beq_taken", 64'h0A07_3306_03FF_FF00, 8'd7, 8'd7, 8'd0, 1'b0, 8'd7);
        addRow(4, "beq_not_taken", 64'h0A07_3306_03FF_FF00, 8'd9, 8'd8, 8'd0, 1'b0, 8'd6);
        addRow(5, "blt_taken", 64'h0A07_5306_03FF_FF00, 8'd3, 8'd7, 8'd0, 1'b0, 8'd7);
        addRow(6, "blt_not_taken", 64'h0A07_5306_03FF_FF00, 8'd7, 8'd8, 8'd0, 1'b0, 8'd6);
        addRow(7, "bdc_dec_loop", 64'h0A03_0211_02FF_0000, 8'd0, 8'd0, 8'd0, 1'b0, 8'd6);
        addRow(8, "brz_after_clr", 64'h0A05_0113_0703_FFFF, 8'd0, 8'd0, 8'd0, 1'b0, 8'd8);
        addRow(9, "bc_after_wrap", 64'h0AFF_0316_0702_FFFF, 8'd0, 8'd0, 8'd0, 1'b1, 8'd8);
        addRow(10, "bnc_not_taken", 64'h0AFF_0315_0702_FFFF, 8'd0, 8'd255, 8'd0, 1'b1, 8'd7);
        addRow(11, "gto_skip", 64'h1204_0303_03FF_0000, 8'd0, 8'd1, 8'd0, 1'b0, 8'd6);
        addRow(12, "unkept_as_nop", 64'h0703_FF00_0000_0000, 8'd0, 8'd1, 8'd0, 1'b0, 8'd3);
        // Last two bytes of RAM are never written and run as NOP
        addRow(13, "run_off_end", 64'h12C8_FF00_0000_0000, 8'd0, 8'd0, 8'd0, 1'b0, 8'd202);
        addRow(14, "jump_past_end", 64'h12E6_FF00_0000_0000, 8'd0, 8'd0, 8'd0, 1'b0, 8'd230);

        for (int r = 0; r < NUM_ROWS; r++) begin
            applyReset();
            for (int i = 0; i < 8; i++) begin
                writeByte(8'(i), rowProgram[r][63 - 8 * i -: 8]);
            end
            writeByte(`VP_ADDR_REGS + 8'd3, rowR3[r]);
            writeByte(`VP_ADDR_REGS + 8'd5, 8'd0);
            runUntilHalt();

            readByte(`VP_ADDR_ACC, value);
            checkValue(rowName[r], "accumulator", int'(rowAcc[r]), int'(value));
            readByte(`VP_ADDR_REGS + 8'd5, value);
            checkValue(rowName[r], "R5", int'(rowR5[r]), int'(value));
            readByte(`VP_ADDR_CONTROL, value);
            checkValue(rowName[r], "carry", int'(rowCarry[r]),
                       int'(value[veriPacMapPkg::CTRL_CARRY_BIT]));
            checkValue(rowName[r], "state", int'(rowState[r]),
                       int'(value[veriPacMapPkg::CTRL_STATE_LSB +: 2]));
            readByte(`VP_ADDR_PC, value);
            checkValue(rowName[r], "pc", int'(rowPc[r]), int'(value));

            // HALT holds through another step
            pulseStep();
            readByte(`VP_ADDR_PC, value);
            checkValue(rowName[r], "pc after extra step", int'(rowPc[r]), int'(value));
            readByte(`VP_ADDR_CONTROL, value);
            checkValue(rowName[r], "state after extra step", int'(ST_HALT),
                       int'(value[veriPacMapPkg::CTRL_STATE_LSB +: 2]));
        end

        // A step edge during a host read waits until the read ends
        applyReset();
        @(posedge clk);
        addr <= `VP_ADDR_PC;
        rd <= 1'b1;
        @(posedge clk);
        step <= 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        checkValue("freeze", "pc with rd high", 0, int'(dout));
        @(posedge clk);
        rd <= 1'b0;
        @(posedge clk);
        step <= 1'b0;
        readByte(`VP_ADDR_PC, value);
        checkValue("freeze", "pc after rd low", 1, int'(value));

        // One long pulse is one step
        applyReset();
        @(posedge clk);
        step <= 1'b1;
        repeat (10) @(posedge clk);
        step <= 1'b0;
        readByte(`VP_ADDR_PC, value);
        checkValue("long_pulse", "pc", 1, int'(value));
        readByte(`VP_ADDR_CONTROL, value);
        checkValue("long_pulse", "state", int'(ST_FETCH2),
                   int'(value[veriPacMapPkg::CTRL_STATE_LSB +: 2]));

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+logic
logic/veriPacIsaPkg.sv
logic/veriPacMapPkg.sv
logic/programRam.sv
logic/registerFile.sv
logic/accumulatorUnit.sv
logic/controlUnit.sv
logic/hostPort.sv
logic/veriPacTop.sv
sim/veriPacTb.sv
